//--- common/rv_isa_pkg.sv
////////////////////////////////////////////////////////////////////////////
// RISC-V ISA definitions for the retire profiler
// Major opcode encoding, the benchmark marker NOP fields and the
// instruction word union with its R-type and I-type views
////////////////////////////////////////////////////////////////////////////

package rv_isa_pkg;

    // Major opcode, instruction bits 6:2
    typedef enum logic [4:0] {
        LOAD_T      = 5'b00000,
        FENCE_T     = 5'b00011,
        ARITH_IMM_T = 5'b00100,
        AUIPC_T     = 5'b00101,
        STORE_T     = 5'b01000,
        ARITH_T     = 5'b01100,
        LUI_T       = 5'b01101,
        BRANCH_T    = 5'b11000,
        JALR_T      = 5'b11001,
        JAL_T       = 5'b11011,
        SYSTEM_T    = 5'b11100
    } opcode_t;

    // Low opcode bits of every 32-bit instruction
    localparam logic [1:0] OPCODE_LOW_32 = 2'b11;
    localparam logic [2:0] ADDI_FN3 = 3'b000;

    // Benchmark start and end markers, addi x0, x0, imm
    localparam logic [11:0] MARKER_START_IMM = 12'd12;
    localparam logic [11:0] MARKER_END_IMM = 12'd13;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_t    opcode;
        logic [1:0] low;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_t     opcode;
        logic [1:0]  low;
    } i_type_t;

    // One retired word, seen either as R-type or as I-type
    typedef union packed {
        r_type_t r_type;
        i_type_t i_type;
    } instr_u;

endpackage

//--- common/profiler_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Profiler definitions
// Instruction mix counter slots, default counter width and the
// per-slot enable vector
////////////////////////////////////////////////////////////////////////////

package profiler_pkg;

    // Counter slots, MIX_NONE also holds the window cycle count
    typedef enum logic [2:0] {
        MIX_ALU   = 3'd0,
        MIX_BR    = 3'd1,
        MIX_MUL   = 3'd2,
        MIX_DIV   = 3'd3,
        MIX_LOAD  = 3'd4,
        MIX_STORE = 3'd5,
        MIX_MISC  = 3'd6,
        MIX_NONE  = 3'd7
    } mix_class_t;

    localparam int NUM_MIX = 8;
    localparam int DEFAULT_COUNT_W = 32;

    // One bit per counter slot
    typedef logic [NUM_MIX-1:0] count_en_t;

endpackage

//--- common/retire_class_if.sv
////////////////////////////////////////////////////////////////////////////
// Classified retire lanes from decode to the counters
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface retire_class_if #(
    parameter int RETIRE_PORTS = 2
);

    logic                     lane_valid [RETIRE_PORTS];
    profiler_pkg::mix_class_t lane_class [RETIRE_PORTS];
    logic                     start_seen;
    logic                     end_seen;

    modport decode (
        output lane_valid, lane_class, start_seen, end_seen
    );

    modport execute (
        input lane_valid, lane_class, start_seen, end_seen
    );

endinterface

//--- rtl/retire_decode.sv
////////////////////////////////////////////////////////////////////////////
// Retire lane decode
// Classifies each retired word into a mix slot and flags the benchmark
// start and end marker NOPs, all outputs registered
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module retire_decode #(
    parameter int RETIRE_PORTS = 2
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               retire_valid [RETIRE_PORTS],
    input  rv_isa_pkg::instr_u retire_instr [RETIRE_PORTS],
    retire_class_if.decode     cls
);

    profiler_pkg::mix_class_t lane_class_nxt [RETIRE_PORTS];
    logic start_nxt;
    logic end_nxt;

    function automatic profiler_pkg::mix_class_t classify(input rv_isa_pkg::instr_u instr);
        logic is_m;
        logic is_div;
        profiler_pkg::mix_class_t mix;
        // M extension flag and divide select
        is_m   = instr.r_type.funct7[0];
        is_div = instr.r_type.funct3[2];
        case (instr.r_type.opcode)
            rv_isa_pkg::ARITH_T: begin
                if (!is_m)
                    mix = profiler_pkg::MIX_ALU;
                else
                    mix = is_div ? profiler_pkg::MIX_DIV : profiler_pkg::MIX_MUL;
            end
            rv_isa_pkg::ARITH_IMM_T, rv_isa_pkg::AUIPC_T, rv_isa_pkg::LUI_T:
                mix = profiler_pkg::MIX_ALU;
            rv_isa_pkg::BRANCH_T, rv_isa_pkg::JAL_T, rv_isa_pkg::JALR_T:
                mix = profiler_pkg::MIX_BR;
            rv_isa_pkg::LOAD_T:   mix = profiler_pkg::MIX_LOAD;
            rv_isa_pkg::STORE_T:  mix = profiler_pkg::MIX_STORE;
            rv_isa_pkg::SYSTEM_T, rv_isa_pkg::FENCE_T:
                mix = profiler_pkg::MIX_MISC;
            default:              mix = profiler_pkg::MIX_NONE;
        endcase
        return mix;
    endfunction

    // addi x0, x0, imm
    function automatic logic is_marker(input rv_isa_pkg::instr_u instr, input logic [11:0] imm);
        return (instr.i_type.low == rv_isa_pkg::OPCODE_LOW_32) &&
               (instr.i_type.opcode == rv_isa_pkg::ARITH_IMM_T) &&
               (instr.i_type.funct3 == rv_isa_pkg::ADDI_FN3) &&
               (instr.i_type.rd == 5'd0) && (instr.i_type.rs1 == 5'd0) &&
               (instr.i_type.imm == imm);
    endfunction

    always_comb begin
        start_nxt = 1'b0;
        end_nxt   = 1'b0;
        for (int i = 0; i < RETIRE_PORTS; i++) begin
            lane_class_nxt[i] = classify(retire_instr[i]);
            if (retire_valid[i] && is_marker(retire_instr[i], rv_isa_pkg::MARKER_START_IMM)) begin
                start_nxt = 1'b1;
                lane_class_nxt[i] = profiler_pkg::MIX_NONE;
            end
            // The end marker itself is never counted
            if (retire_valid[i] && is_marker(retire_instr[i], rv_isa_pkg::MARKER_END_IMM)) begin
                end_nxt = 1'b1;
                lane_class_nxt[i] = profiler_pkg::MIX_NONE;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < RETIRE_PORTS; i++)
                cls.lane_valid[i] <= 1'b0;
            cls.start_seen <= 1'b0;
            cls.end_seen   <= 1'b0;
        end else begin
            for (int i = 0; i < RETIRE_PORTS; i++)
                cls.lane_valid[i] <= retire_valid[i];
            cls.start_seen <= start_nxt;
            cls.end_seen   <= end_nxt;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < RETIRE_PORTS; i++)
            cls.lane_class[i] <= lane_class_nxt[i];
    end

    // Core must not retire both markers in one cycle
    a_markers_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        !(cls.start_seen && cls.end_seen));

endmodule

//--- rtl/mix_counters.sv
////////////////////////////////////////////////////////////////////////////
// Collection window and instruction mix counters
// Saturating per-class counters plus a window cycle counter
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mix_counters #(
    parameter int RETIRE_PORTS = 2,
    parameter int COUNT_W      = 32
) (
    input  logic                 clk,
    input  logic                 arst_n,
    retire_class_if.execute      cls,
    output logic [COUNT_W-1:0]   counts [profiler_pkg::NUM_MIX],
    output logic                 collecting
);

    // Enough bits for every lane hitting one class
    localparam int INC_W = $clog2(RETIRE_PORTS + 1);

    profiler_pkg::count_en_t lane_hit [RETIRE_PORTS];
    logic [INC_W-1:0]        inc      [profiler_pkg::NUM_MIX];
    logic [COUNT_W:0]        sum      [profiler_pkg::NUM_MIX];

    ////////////////////////////////////////////////////////////////////////////
    // Increment per slot

    always_comb begin
        for (int l = 0; l < RETIRE_PORTS; l++) begin
            lane_hit[l] = '0;
            if (cls.lane_valid[l] && cls.lane_class[l] != profiler_pkg::MIX_NONE)
                lane_hit[l][cls.lane_class[l]] = 1'b1;
        end
        for (int c = 0; c < profiler_pkg::NUM_MIX; c++) begin
            inc[c] = '0;
            for (int l = 0; l < RETIRE_PORTS; l++)
                inc[c] = inc[c] + INC_W'(lane_hit[l][c]);
        end
        // Cycle slot counts every window cycle
        inc[int'(profiler_pkg::MIX_NONE)] = INC_W'(1);
        for (int c = 0; c < profiler_pkg::NUM_MIX; c++)
            sum[c] = {1'b0, counts[c]} + (COUNT_W + 1)'(inc[c]);
    end

    ////////////////////////////////////////////////////////////////////////////
    // Window state and counters

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            collecting <= 1'b0;
            for (int c = 0; c < profiler_pkg::NUM_MIX; c++)
                counts[c] <= '0;
        end else if (cls.start_seen) begin
            // Lanes beside the start marker are dropped
            collecting <= 1'b1;
            for (int c = 0; c < profiler_pkg::NUM_MIX; c++)
                counts[c] <= '0;
        end else begin
            if (cls.end_seen)
                collecting <= 1'b0;
            if (collecting) begin
                for (int c = 0; c < profiler_pkg::NUM_MIX; c++)
                    counts[c] <= sum[c][COUNT_W] ? '1 : sum[c][COUNT_W-1:0];
            end
        end
    end

    // Counters only move down when a start marker clears them
    for (genvar c = 0; c < profiler_pkg::NUM_MIX; c++) begin : g_no_decrease
        a_no_decrease: assert property (@(posedge clk) disable iff (!arst_n)
            !$past(cls.start_seen) |-> (counts[c] >= $past(counts[c])));
    end

endmodule

//--- rtl/count_readout.sv
////////////////////////////////////////////////////////////////////////////
// Counter readback
// Valid/ready query port with a one-entry response register
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module count_readout #(
    parameter int COUNT_W = profiler_pkg::DEFAULT_COUNT_W
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic [COUNT_W-1:0]       counts [profiler_pkg::NUM_MIX],
    input  logic                     query_valid,
    input  profiler_pkg::mix_class_t query_sel,
    output logic                     query_ready,
    output logic                     resp_valid,
    output logic [COUNT_W-1:0]       resp_count,
    input  logic                     resp_ready
);

    logic accept;

    // Single outstanding response
    assign query_ready = !resp_valid;
    assign accept      = query_valid && query_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            resp_valid <= 1'b0;
        else if (accept)
            resp_valid <= 1'b1;
        else if (resp_ready)
            resp_valid <= 1'b0;
    end

    // Snapshot of the selected counter at acceptance
    always_ff @(posedge clk) begin
        if (accept)
            resp_count <= counts[query_sel];
    end

    // Response holds under back-pressure
    a_resp_stable: assert property (@(posedge clk) disable iff (!arst_n)
        (resp_valid && !resp_ready) |=> (resp_valid && $stable(resp_count)));

endmodule

//--- rtl/retire_profiler.sv
////////////////////////////////////////////////////////////////////////////
// Retire trace profiler top level
// Decode, mix counters and counter readback
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module retire_profiler #(
    parameter int RETIRE_PORTS = 2,
    parameter int COUNT_W      = profiler_pkg::DEFAULT_COUNT_W
) (
    input  logic                     clk,
    input  logic                     arst_n,
    // Retire ports of the core
    input  logic                     retire_valid [RETIRE_PORTS],
    input  logic [31:0]              retire_instr [RETIRE_PORTS],
    // Query and response
    input  logic                     query_valid,
    input  profiler_pkg::mix_class_t query_sel,
    output logic                     query_ready,
    output logic                     resp_valid,
    output logic [COUNT_W-1:0]       resp_count,
    input  logic                     resp_ready,
    // Window status
    output logic                     collecting
);

    logic [COUNT_W-1:0] counts [profiler_pkg::NUM_MIX];

    retire_class_if #(.RETIRE_PORTS(RETIRE_PORTS)) cls_if ();

    retire_decode #(
        .RETIRE_PORTS (RETIRE_PORTS)
    ) retire_decode_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .retire_valid (retire_valid),
        .retire_instr (retire_instr),
        .cls          (cls_if)
    );

    mix_counters #(
        .RETIRE_PORTS (RETIRE_PORTS),
        .COUNT_W      (COUNT_W)
    ) mix_counters_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .cls        (cls_if),
        .counts     (counts),
        .collecting (collecting)
    );

    count_readout #(
        .COUNT_W (COUNT_W)
    ) count_readout_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .counts      (counts),
        .query_valid (query_valid),
        .query_sel   (query_sel),
        .query_ready (query_ready),
        .resp_valid  (resp_valid),
        .resp_count  (resp_count),
        .resp_ready  (resp_ready)
    );

endmodule

//--- sim/tb_retire_profiler.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the retire profiler
// Directed tests, reference classifier with expected counts, LFSR words,
// compare tasks, clock, reset and cycle limit
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_retire_profiler;

    localparam int LANES      = 2;
    localparam int COUNT_W    = 32;
    localparam int MAX_CYCLES = 4000;
    localparam logic [31:0] START_WORD = {rv_isa_pkg::MARKER_START_IMM, 20'h00013};
    localparam logic [31:0] END_WORD   = {rv_isa_pkg::MARKER_END_IMM, 20'h00013};
    // add, mul, div, divu, mulh, addi, lui, auipc, beq, jal, jalr, lw, sw, ecall, fence, rem
    localparam logic [31:0] MIX_WORDS [16] = '{
        32'h003100B3, 32'h023100B3, 32'h023140B3, 32'h023150B3,
        32'h023110B3, 32'h00500093, 32'h000010B7, 32'h00000097,
        32'h00208463, 32'h008000EF, 32'h000080E7, 32'h0000A083,
        32'h0010A023, 32'h00000073, 32'h0FF0000F, 32'h023160B3
    };

    logic                     clk;
    logic                     arst_n;
    logic                     retire_valid [LANES];
    logic [31:0]              retire_instr [LANES];
    logic                     query_valid;
    profiler_pkg::mix_class_t query_sel;
    logic                     query_ready;
    logic                     resp_valid;
    logic [COUNT_W-1:0]       resp_count;
    logic                     resp_ready;
    logic                     collecting;

    // Scoreboard and window state of the model
    logic [COUNT_W-1:0] exp_count [profiler_pkg::NUM_MIX];
    logic               model_open;
    logic [31:0]        lfsr;
    int                 cycles;
    int                 checks;
    int                 mismatches;
    int                 other_errors;

    retire_profiler #(
        .RETIRE_PORTS (LANES),
        .COUNT_W      (COUNT_W)
    ) retire_profiler_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .retire_valid (retire_valid),
        .retire_instr (retire_instr),
        .query_valid  (query_valid),
        .query_sel    (query_sel),
        .query_ready  (query_ready),
        .resp_valid   (resp_valid),
        .resp_count   (resp_count),
        .resp_ready   (resp_ready),
        .collecting   (collecting)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("ERROR: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model

    function automatic profiler_pkg::mix_class_t ref_class(input logic [31:0] w);
        logic [4:0] op;
        op = w[6:2];
        case (op)
            rv_isa_pkg::ARITH_T:
                if (!w[25])
                    return profiler_pkg::MIX_ALU;
                else
                    return w[14] ? profiler_pkg::MIX_DIV : profiler_pkg::MIX_MUL;
            rv_isa_pkg::ARITH_IMM_T, rv_isa_pkg::AUIPC_T, rv_isa_pkg::LUI_T:
                return profiler_pkg::MIX_ALU;
            rv_isa_pkg::BRANCH_T, rv_isa_pkg::JAL_T, rv_isa_pkg::JALR_T:
                return profiler_pkg::MIX_BR;
            rv_isa_pkg::LOAD_T:   return profiler_pkg::MIX_LOAD;
            rv_isa_pkg::STORE_T:  return profiler_pkg::MIX_STORE;
            rv_isa_pkg::SYSTEM_T, rv_isa_pkg::FENCE_T:
                return profiler_pkg::MIX_MISC;
            default:              return profiler_pkg::MIX_NONE;
        endcase
    endfunction

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic next_word(output logic [31:0] w);
        w = '0;
        for (int b = 0; b < 32; b++) begin
            lfsr = lfsr_step(lfsr);
            w = {w[30:0], lfsr[0]};
        end
        w[1:0] = 2'b11;
        // Keep random words off the markers
        if (w == START_WORD || w == END_WORD)
            w[7] = 1'b1;
    endtask

    // One clock of retire traffic, mirrored into the scoreboard
    task automatic drive_cycle(input logic v0, input logic [31:0] w0,
                               input logic v1, input logic [31:0] w1);
        logic                     v [LANES];
        logic [31:0]              w [LANES];
        logic                     st;
        logic                     en;
        profiler_pkg::mix_class_t c;
        v[0] = v0;
        v[1] = v1;
        w[0] = w0;
        w[1] = w1;
        st = 1'b0;
        en = 1'b0;
        for (int i = 0; i < LANES; i++) begin
            retire_valid[i] = v[i];
            retire_instr[i] = w[i];
            st = st | (v[i] && w[i] == START_WORD);
            en = en | (v[i] && w[i] == END_WORD);
        end
        if (st) begin
            for (int s = 0; s < profiler_pkg::NUM_MIX; s++)
                exp_count[s] = '0;
            model_open = 1'b1;
        end else if (model_open) begin
            for (int i = 0; i < LANES; i++) begin
                c = ref_class(w[i]);
                if (v[i] && w[i] != END_WORD && c != profiler_pkg::MIX_NONE && exp_count[c] != '1)
                    exp_count[c] = exp_count[c] + 1'b1;
            end
            if (exp_count[profiler_pkg::MIX_NONE] != '1)
                exp_count[profiler_pkg::MIX_NONE] = exp_count[profiler_pkg::MIX_NONE] + 1'b1;
            if (en)
                model_open = 1'b0;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic settle();
        repeat (3) drive_cycle(1'b0, '0, 1'b0, '0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Query port and compare tasks

    task automatic check_count(input string name, input logic [COUNT_W-1:0] got,
                               input logic [COUNT_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic read_count(input profiler_pkg::mix_class_t sel,
                              output logic [COUNT_W-1:0] value);
        int   waited;
        logic took;
        query_valid = 1'b1;
        query_sel   = sel;
        waited      = 0;
        took        = 1'b0;
        while (!took && waited < 20) begin
            took = query_ready;
            @(posedge clk);
            #1;
            waited++;
        end
        query_valid = 1'b0;
        if (!took) begin
            other_errors++;
            $display("ERROR: query for slot %0d was never accepted", sel);
        end
        waited = 0;
        while (!resp_valid && waited < 20) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!resp_valid) begin
            other_errors++;
            $display("ERROR: no response arrived for slot %0d", sel);
        end
        value = resp_count;
        // Response leaves on this edge when the host is ready
        if (resp_ready) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic check_all_counts();
        logic [COUNT_W-1:0] v;
        for (int s = 0; s < profiler_pkg::NUM_MIX; s++) begin
            read_count(profiler_pkg::mix_class_t'(s), v);
            check_count($sformatf("resp_count[slot %0d]", s), v, exp_count[s]);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests

    task automatic test_reset_state();
        check_flag("collecting", collecting, 1'b0);
        check_flag("query_ready", query_ready, 1'b1);
        check_all_counts();
    endtask

    task automatic test_window_open();
        drive_cycle(1'b1, MIX_WORDS[0], 1'b1, MIX_WORDS[11]);
        drive_cycle(1'b1, MIX_WORDS[1], 1'b1, MIX_WORDS[12]);
        settle();
        check_all_counts();
        drive_cycle(1'b1, START_WORD, 1'b0, '0);
        settle();
        check_flag("collecting", collecting, 1'b1);
    endtask

    task automatic test_mixed_stream();
        for (int k = 0; k < 16; k += 2)
            drive_cycle(1'b1, MIX_WORDS[k], 1'b1, MIX_WORDS[k+1]);
        drive_cycle(1'b1, END_WORD, 1'b0, '0);
        settle();
        check_flag("collecting", collecting, 1'b0);
        check_all_counts();
        // Closed window ignores traffic
        drive_cycle(1'b1, MIX_WORDS[2], 1'b1, MIX_WORDS[8]);
        settle();
        check_all_counts();
    endtask

    task automatic test_random_words();
        logic [31:0] w0;
        logic [31:0] w1;
        drive_cycle(1'b1, START_WORD, 1'b0, '0);
        for (int k = 0; k < 150; k++) begin
            next_word(w0);
            next_word(w1);
            drive_cycle(1'b1, w0, 1'b1, w1);
        end
        drive_cycle(1'b0, '0, 1'b1, END_WORD);
        settle();
        check_all_counts();
    endtask

    task automatic test_marker_lanes();
        drive_cycle(1'b1, MIX_WORDS[0], 1'b1, START_WORD);
        drive_cycle(1'b1, MIX_WORDS[11], 1'b1, MIX_WORDS[12]);
        drive_cycle(1'b1, END_WORD, 1'b1, MIX_WORDS[11]);
        settle();
        check_all_counts();
    endtask

    task automatic test_backpressure();
        logic [COUNT_W-1:0] held;
        logic [COUNT_W-1:0] next;
        resp_ready = 1'b0;
        read_count(profiler_pkg::MIX_LOAD, held);
        check_count("resp_count", held, exp_count[profiler_pkg::MIX_LOAD]);
        // A second query waits behind the held response
        query_valid = 1'b1;
        query_sel   = profiler_pkg::MIX_STORE;
        repeat (6) begin
            @(posedge clk);
            #1;
            check_count("resp_count", resp_count, exp_count[profiler_pkg::MIX_LOAD]);
            check_flag("query_ready", query_ready, 1'b0);
            check_flag("resp_valid", resp_valid, 1'b1);
        end
        resp_ready = 1'b1;
        @(posedge clk);
        #1;
        check_flag("query_ready", query_ready, 1'b1);
        read_count(profiler_pkg::MIX_STORE, next);
        check_count("resp_count", next, exp_count[profiler_pkg::MIX_STORE]);
    endtask

    initial begin
        arst_n       = 1'b0;
        query_valid  = 1'b0;
        query_sel    = profiler_pkg::MIX_ALU;
        resp_ready   = 1'b1;
        model_open   = 1'b0;
        lfsr         = 32'h9b40_6a0c;
        cycles       = 0;
        checks       = 0;
        mismatches   = 0;
        other_errors = 0;
        for (int i = 0; i < LANES; i++) begin
            retire_valid[i] = 1'b0;
            retire_instr[i] = '0;
        end
        for (int s = 0; s < profiler_pkg::NUM_MIX; s++)
            exp_count[s] = '0;
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;

        test_reset_state();
        test_window_open();
        test_mixed_stream();
        test_random_words();
        test_marker_lanes();
        test_backpressure();

        $display("Checks: %0d, mismatches: %0d, other errors: %0d",
                 checks, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

//--- retire_profiler.f
common/rv_isa_pkg.sv
common/profiler_pkg.sv
common/retire_class_if.sv
rtl/retire_decode.sv
rtl/mix_counters.sv
rtl/count_readout.sv
rtl/retire_profiler.sv
sim/tb_retire_profiler.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_retire_profiler
FLIST     ?= retire_profiler.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Test completed successfully

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
